//--- verilog/mipsPkg.sv
/* Datapath widths, opcode, funct and ALU operation codes,
   and the instruction word read as R-format or I-format */
package mipsPkg;

   // Datapath widths
   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 5;
   localparam int aluCtlWidth  = 3;

   // Primary opcodes
   localparam logic [5:0] opRType = 6'h00;
   localparam logic [5:0] opAddi  = 6'h08;
   localparam logic [5:0] opLw    = 6'h23;
   localparam logic [5:0] opSw    = 6'h2b;
   localparam logic [5:0] opBeq   = 6'h04;

   // R-type funct field
   localparam logic [5:0] functAdd = 6'h20;
   localparam logic [5:0] functSub = 6'h22;
   localparam logic [5:0] functAnd = 6'h24;
   localparam logic [5:0] functOr  = 6'h25;
   localparam logic [5:0] functSlt = 6'h2a;

   // ALU operation codes
   localparam logic [aluCtlWidth-1:0] aluAnd = 3'd0;
   localparam logic [aluCtlWidth-1:0] aluOr  = 3'd1;
   localparam logic [aluCtlWidth-1:0] aluAdd = 3'd2;
   localparam logic [aluCtlWidth-1:0] aluSub = 3'd6;
   localparam logic [aluCtlWidth-1:0] aluSlt = 3'd7;

   // One instruction word, two field layouts
   typedef union packed {
      struct packed {
         logic [5:0]              opcode;
         logic [regAddrWidth-1:0] rs;
         logic [regAddrWidth-1:0] rt;
         logic [regAddrWidth-1:0] rd;
         logic [4:0]              shamt;
         logic [5:0]              funct;
      } rType;
      struct packed {
         logic [5:0]              opcode;
         logic [regAddrWidth-1:0] rs;
         logic [regAddrWidth-1:0] rt;
         logic [15:0]             imm;
      } iType;
   } instrWord;

endpackage

//--- verilog/fetchStage.sv
/* Program counter, next-PC select and the IF/ID register */
module fetchStage import mipsPkg::*; (
   input  logic                 Clk,
   input  logic                 reset,
   input  logic                 stall,
   input  logic                 branchTaken,
   input  logic [dataWidth-1:0] branchTarget,
   input  instrWord             instr,
   output logic [dataWidth-1:0] pc,
   output instrWord             instrId,
   output logic [dataWidth-1:0] pcPlus4Id
);

   logic [dataWidth-1:0] pcPlus4;
   logic [dataWidth-1:0] nextPc;

   assign pcPlus4 = pc + dataWidth'(4);

   // Branch redirect wins, stall holds the current fetch
   always_comb begin
      if (branchTaken) begin
         nextPc = branchTarget;
      end else if (stall) begin
         nextPc = pc;
      end else begin
         nextPc = pcPlus4;
      end
   end

   always_ff @(posedge Clk) begin
      if (reset) begin
         pc <= '0;
      end else begin
         pc <= nextPc;
      end
   end

   // IF/ID instruction, zero word acts as the bubble
   always_ff @(posedge Clk) begin
      if (reset) begin
         instrId <= '0;
      end else if (branchTaken) begin
         // Squash the word fetched behind the beq
         instrId <= '0;
      end else if (!stall) begin
         instrId <= instr;
      end
   end

   // Return address rides along for the branch adder
   always_ff @(posedge Clk) begin
      if (!stall) begin
         pcPlus4Id <= pcPlus4;
      end
   end

endmodule

//--- verilog/decodeStage.sv
/* Register file, control decode, hazard detection,
   branch compare and the ID/EX register */
module decodeStage import mipsPkg::*; (
   input  logic                    Clk,
   input  logic                    reset,
   input  instrWord                instrId,
   input  logic [dataWidth-1:0]    pcPlus4Id,
   input  logic                    wbEnable,
   input  logic [regAddrWidth-1:0] wbAddr,
   input  logic [dataWidth-1:0]    wbData,
   input  logic                    memRegWrite,
   input  logic [regAddrWidth-1:0] memDest,
   output logic                    stall,
   output logic                    branchTaken,
   output logic [dataWidth-1:0]    branchTarget,
   output logic                    exRegWrite,
   output logic                    exMemRead,
   output logic                    exMemWrite,
   output logic                    exAluSrc,
   output logic [aluCtlWidth-1:0]  exAluCtl,
   output logic [regAddrWidth-1:0] exRs,
   output logic [regAddrWidth-1:0] exRt,
   output logic [regAddrWidth-1:0] exDest,
   output logic [dataWidth-1:0]    exOperandA,
   output logic [dataWidth-1:0]    exOperandB,
   output logic [dataWidth-1:0]    exImm
);

   localparam int numRegs = 1 << regAddrWidth;

   logic [dataWidth-1:0]    regFile [numRegs];
   logic [regAddrWidth-1:0] rs;
   logic [regAddrWidth-1:0] rt;
   logic [dataWidth-1:0]    readA;
   logic [dataWidth-1:0]    readB;
   logic [dataWidth-1:0]    immExt;
   logic                    isBeq;
   logic                    usesRt;
   logic                    regWrite;
   logic                    memRead;
   logic                    memWrite;
   logic                    aluSrc;
   logic [aluCtlWidth-1:0]  aluCtl;
   logic [regAddrWidth-1:0] dest;
   logic                    loadUse;
   logic                    branchWait;

   // Register 0 reads as zero; a same-cycle write passes straight through
   function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] addr);
      if (addr == '0) begin
         return '0;
      end else if (wbEnable && (wbAddr == addr)) begin
         return wbData;
      end
      return regFile[addr];
   endfunction

   assign rs     = instrId.rType.rs;
   assign rt     = instrId.rType.rt;
   assign immExt = {{(dataWidth-16){instrId.iType.imm[15]}}, instrId.iType.imm};

   always_ff @(posedge Clk) begin
      if (wbEnable && (wbAddr != '0)) begin
         regFile[wbAddr] <= wbData;
      end
   end

   always_comb begin
      readA = readReg(rs);
      readB = readReg(rt);
   end

   // Main decoder
   always_comb begin
      regWrite = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      aluSrc   = 1'b0;
      aluCtl   = aluAdd;
      dest     = rt;
      case (instrId.rType.opcode)
         opRType: begin
            regWrite = 1'b1;
            dest     = instrId.rType.rd;
            case (instrId.rType.funct)
               functSub: aluCtl = aluSub;
               functAnd: aluCtl = aluAnd;
               functOr:  aluCtl = aluOr;
               functSlt: aluCtl = aluSlt;
               default:  aluCtl = aluAdd;
            endcase
         end
         opAddi: begin
            regWrite = 1'b1;
            aluSrc   = 1'b1;
         end
         opLw: begin
            regWrite = 1'b1;
            memRead  = 1'b1;
            aluSrc   = 1'b1;
         end
         opSw: begin
            memWrite = 1'b1;
            aluSrc   = 1'b1;
         end
         default: begin
            // beq and unknown opcodes write nothing
            regWrite = 1'b0;
         end
      endcase
   end

   assign isBeq  = (instrId.rType.opcode == opBeq);
   // rt is a source only for R-type, sw and beq
   assign usesRt = (instrId.rType.opcode == opRType) || (instrId.rType.opcode == opSw) || isBeq;

   // Load result not ready for the next instruction
   assign loadUse = exMemRead && (exDest != '0) &&
                    ((exDest == rs) || (usesRt && (exDest == rt)));

   // Comparator only sees register file or writeback values
   assign branchWait = isBeq &&
      ((exRegWrite && (exDest != '0) && ((exDest == rs) || (exDest == rt))) ||
       (memRegWrite && (memDest != '0) && ((memDest == rs) || (memDest == rt))));

   assign stall        = loadUse || branchWait;
   assign branchTaken  = isBeq && !stall && (readA == readB);
   assign branchTarget = pcPlus4Id + {immExt[dataWidth-3:0], 2'b00};

   // ID/EX control, bubble on stall
   always_ff @(posedge Clk) begin
      if (reset || stall) begin
         exRegWrite <= 1'b0;
         exMemRead  <= 1'b0;
         exMemWrite <= 1'b0;
         exAluSrc   <= 1'b0;
         exAluCtl   <= aluAdd;
      end else begin
         exRegWrite <= regWrite;
         exMemRead  <= memRead;
         exMemWrite <= memWrite;
         exAluSrc   <= aluSrc;
         exAluCtl   <= aluCtl;
      end
   end

   // ID/EX payload
   always_ff @(posedge Clk) begin
      exRs       <= rs;
      exRt       <= rt;
      exDest     <= dest;
      exOperandA <= readA;
      exOperandB <= readB;
      exImm      <= immExt;
   end

endmodule

//--- verilog/executeStage.sv
/* Operand forwarding, ALU and the EX/MEM register */
module executeStage import mipsPkg::*; (
   input  logic                    Clk,
   input  logic                    reset,
   input  logic                    exRegWrite,
   input  logic                    exMemRead,
   input  logic                    exMemWrite,
   input  logic                    exAluSrc,
   input  logic [aluCtlWidth-1:0]  exAluCtl,
   input  logic [regAddrWidth-1:0] exRs,
   input  logic [regAddrWidth-1:0] exRt,
   input  logic [regAddrWidth-1:0] exDest,
   input  logic [dataWidth-1:0]    exOperandA,
   input  logic [dataWidth-1:0]    exOperandB,
   input  logic [dataWidth-1:0]    exImm,
   input  logic                    wbEnable,
   input  logic [regAddrWidth-1:0] wbAddr,
   input  logic [dataWidth-1:0]    wbData,
   output logic                    memRegWrite,
   output logic                    memMemRead,
   output logic                    memMemWrite,
   output logic [regAddrWidth-1:0] memDest,
   output logic [dataWidth-1:0]    memAluResult,
   output logic [dataWidth-1:0]    memStoreData
);

   logic [dataWidth-1:0] aluA;
   logic [dataWidth-1:0] storeData;
   logic [dataWidth-1:0] aluB;
   logic [dataWidth-1:0] aluResult;

   // Newest producer wins: EX/MEM first, then writeback
   function automatic logic [dataWidth-1:0] forwardOperand(
      input logic [regAddrWidth-1:0] src,
      input logic [dataWidth-1:0]    idValue
   );
      if (src == '0) begin
         return idValue;
      end else if (memRegWrite && !memMemRead && (memDest == src)) begin
         // A load in EX/MEM never lands here, decode stalls for it
         return memAluResult;
      end else if (wbEnable && (wbAddr == src)) begin
         return wbData;
      end
      return idValue;
   endfunction

   always_comb begin
      aluA      = forwardOperand(exRs, exOperandA);
      storeData = forwardOperand(exRt, exOperandB);
      // Immediate for addi, lw and sw
      aluB      = exAluSrc ? exImm : storeData;
   end

   // ALU
   always_comb begin
      case (exAluCtl)
         aluAdd:  aluResult = aluA + aluB;
         aluSub:  aluResult = aluA - aluB;
         aluAnd:  aluResult = aluA & aluB;
         aluOr:   aluResult = aluA | aluB;
         aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, ($signed(aluA) < $signed(aluB))};
         default: aluResult = '0;
      endcase
   end

   // EX/MEM control
   always_ff @(posedge Clk) begin
      if (reset) begin
         memRegWrite <= 1'b0;
         memMemRead  <= 1'b0;
         memMemWrite <= 1'b0;
      end else begin
         memRegWrite <= exRegWrite;
         memMemRead  <= exMemRead;
         memMemWrite <= exMemWrite;
      end
   end

   // EX/MEM payload
   always_ff @(posedge Clk) begin
      memDest      <= exDest;
      memAluResult <= aluResult;
      memStoreData <= storeData;
   end

endmodule

//--- verilog/memoryStage.sv
/* Data memory, MEM/WB register and writeback select */
module memoryStage import mipsPkg::*; #(
   parameter int dataMemWords = 64
) (
   input  logic                    Clk,
   input  logic                    reset,
   input  logic                    memRegWrite,
   input  logic                    memMemRead,
   input  logic                    memMemWrite,
   input  logic [regAddrWidth-1:0] memDest,
   input  logic [dataWidth-1:0]    memAluResult,
   input  logic [dataWidth-1:0]    memStoreData,
   output logic                    wbEnable,
   output logic [regAddrWidth-1:0] wbAddr,
   output logic [dataWidth-1:0]    wbData
);

   localparam int memAddrWidth = $clog2(dataMemWords);

   logic [dataWidth-1:0]    dataMem [dataMemWords];
   logic [memAddrWidth-1:0] wordAddr;
   logic [dataWidth-1:0]    readData;
   logic [dataWidth-1:0]    resultData;

   // Byte address in, drop the two offset bits
   assign wordAddr = memAluResult[memAddrWidth+1:2];

   // Asynchronous read
   assign readData = dataMem[wordAddr];

   // Synchronous write
   always_ff @(posedge Clk) begin
      if (memMemWrite) begin
         dataMem[wordAddr] <= memStoreData;
      end
   end

   // Load data or ALU result
   assign resultData = memMemRead ? readData : memAluResult;

   // MEM/WB control
   always_ff @(posedge Clk) begin
      if (reset) begin
         wbEnable <= 1'b0;
      end else begin
         // Writes to register 0 are dropped here
         wbEnable <= memRegWrite && (memDest != '0);
      end
   end

   // MEM/WB payload
   always_ff @(posedge Clk) begin
      wbAddr <= memDest;
      wbData <= resultData;
   end

endmodule

//--- verilog/mipsCore.sv
/* Five-stage pipeline top level wiring fetch, decode,
   execute and memory stages */
module mipsCore #(
   parameter int dataMemWords = 64
) (
   input  logic                          Clk,
   input  logic                          reset,
   input  mipsPkg::instrWord             instr,
   output logic [mipsPkg::dataWidth-1:0] pc,
   output logic                          wbEnable,
   output logic [mipsPkg::regAddrWidth-1:0] wbAddr,
   output logic [mipsPkg::dataWidth-1:0] wbData
);

   // IF/ID
   mipsPkg::instrWord                 instrId;
   logic [mipsPkg::dataWidth-1:0]     pcPlus4Id;

   // Decode back to fetch
   logic                              stall;
   logic                              branchTaken;
   logic [mipsPkg::dataWidth-1:0]     branchTarget;

   // ID/EX
   logic                              exRegWrite;
   logic                              exMemRead;
   logic                              exMemWrite;
   logic                              exAluSrc;
   logic [mipsPkg::aluCtlWidth-1:0]   exAluCtl;
   logic [mipsPkg::regAddrWidth-1:0]  exRs;
   logic [mipsPkg::regAddrWidth-1:0]  exRt;
   logic [mipsPkg::regAddrWidth-1:0]  exDest;
   logic [mipsPkg::dataWidth-1:0]     exOperandA;
   logic [mipsPkg::dataWidth-1:0]     exOperandB;
   logic [mipsPkg::dataWidth-1:0]     exImm;

   // EX/MEM
   logic                              memRegWrite;
   logic                              memMemRead;
   logic                              memMemWrite;
   logic [mipsPkg::regAddrWidth-1:0]  memDest;
   logic [mipsPkg::dataWidth-1:0]     memAluResult;
   logic [mipsPkg::dataWidth-1:0]     memStoreData;

   // Producer, PC and IF/ID
   fetchStage fetch_i (
      .Clk          (Clk),
      .reset        (reset),
      .stall        (stall),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .instr        (instr),
      .pc           (pc),
      .instrId      (instrId),
      .pcPlus4Id    (pcPlus4Id)
   );

   // Register file, hazards, branch and ID/EX
   decodeStage decode_i (
      .Clk          (Clk),
      .reset        (reset),
      .instrId      (instrId),
      .pcPlus4Id    (pcPlus4Id),
      .wbEnable     (wbEnable),
      .wbAddr       (wbAddr),
      .wbData       (wbData),
      .memRegWrite  (memRegWrite),
      .memDest      (memDest),
      .stall        (stall),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .exRegWrite   (exRegWrite),
      .exMemRead    (exMemRead),
      .exMemWrite   (exMemWrite),
      .exAluSrc     (exAluSrc),
      .exAluCtl     (exAluCtl),
      .exRs         (exRs),
      .exRt         (exRt),
      .exDest       (exDest),
      .exOperandA   (exOperandA),
      .exOperandB   (exOperandB),
      .exImm        (exImm)
   );

   // Forwarding, ALU and EX/MEM
   executeStage execute_i (
      .Clk          (Clk),
      .reset        (reset),
      .exRegWrite   (exRegWrite),
      .exMemRead    (exMemRead),
      .exMemWrite   (exMemWrite),
      .exAluSrc     (exAluSrc),
      .exAluCtl     (exAluCtl),
      .exRs         (exRs),
      .exRt         (exRt),
      .exDest       (exDest),
      .exOperandA   (exOperandA),
      .exOperandB   (exOperandB),
      .exImm        (exImm),
      .wbEnable     (wbEnable),
      .wbAddr       (wbAddr),
      .wbData       (wbData),
      .memRegWrite  (memRegWrite),
      .memMemRead   (memMemRead),
      .memMemWrite  (memMemWrite),
      .memDest      (memDest),
      .memAluResult (memAluResult),
      .memStoreData (memStoreData)
   );

   // Data memory and MEM/WB
   memoryStage #(
      .dataMemWords (dataMemWords)
   ) memory_i (
      .Clk          (Clk),
      .reset        (reset),
      .memRegWrite  (memRegWrite),
      .memMemRead   (memMemRead),
      .memMemWrite  (memMemWrite),
      .memDest      (memDest),
      .memAluResult (memAluResult),
      .memStoreData (memStoreData),
      .wbEnable     (wbEnable),
      .wbAddr       (wbAddr),
      .wbData       (wbData)
   );

endmodule

//--- sim/clockGen.sv
/* Testbench clock and synchronous reset generator */
module clockGen #(
   parameter int period      = 100,
   parameter int resetCycles = 3,
   parameter int driveDelay  = 10
) (
   output logic Clk,
   output logic reset
);

   initial begin
      Clk = 1'b0;
      forever #(period / 2) Clk = ~Clk;
   end

   // Reset drops just after the last reset edge
   initial begin
      reset = 1'b1;
      repeat (resetCycles) @(posedge Clk);
      #driveDelay;
      reset = 1'b0;
   end

endmodule

//--- sim/coreProps.sv
/* Concurrent checks on the core write port and fetch address,
   bound into mipsCore */
module coreProps import mipsPkg::*; (
   input logic                    Clk,
   input logic                    reset,
   input logic [dataWidth-1:0]    pc,
   input logic                    wbEnable,
   input logic [regAddrWidth-1:0] wbAddr,
   input logic [dataWidth-1:0]    wbData
);

   // Register 0 never reaches the write port
   noZeroWrite: assert property (@(posedge Clk) disable iff (reset)
      !(wbEnable && (wbAddr == '0)))
      else $error("write port enabled for register 0");

   // Fetch address stays on a word boundary
   pcAligned: assert property (@(posedge Clk) disable iff (reset)
      pc[1:0] == 2'b00)
      else $error("pc 0x%h is not word aligned", pc);

   // Enable itself is always known out of reset
   enableKnown: assert property (@(posedge Clk) disable iff (reset)
      !$isunknown(wbEnable))
      else $error("wbEnable is unknown");

   // Payload only matters while enabled
   writeKnown: assert property (@(posedge Clk) disable iff (reset)
      wbEnable |-> !$isunknown({wbAddr, wbData}))
      else $error("write port address or data unknown while enabled");

endmodule

bind mipsCore coreProps props_i (.*);

//--- sim/coreTb.sv
/* Testbench top: instruction memory from the stim file,
   writeback stream checking and watchdog */
module coreTb import mipsPkg::*; ();

   localparam int    clkPeriod  = 100;
   localparam int    driveDelay = 10;
   localparam int    stimDepth  = 256;
   localparam int    progDepth  = 128;
   localparam string stimFile   = "sim/programStim.txt";

   logic                    Clk;
   logic                    reset;
   instrWord                instr;
   logic [dataWidth-1:0]    pc;
   logic                    wbEnable;
   logic [regAddrWidth-1:0] wbAddr;
   logic [dataWidth-1:0]    wbData;

   // Raw stim words, then the program after filler randomization
   logic [31:0]             stim [stimDepth];
   instrWord                progMem [progDepth];
   int                      progLen;
   int                      expCount;
   int                      expBase;
   int                      checkedCount;
   bit                      loaded;
   integer                  seed;

   clockGen #(
      .period      (clkPeriod),
      .resetCycles (3),
      .driveDelay  (driveDelay)
   ) clock_i (
      .Clk   (Clk),
      .reset (reset)
   );

   mipsCore #(
      .dataMemWords (64)
   ) dut_i (
      .Clk      (Clk),
      .reset    (reset),
      .instr    (instr),
      .pc       (pc),
      .wbEnable (wbEnable),
      .wbAddr   (wbAddr),
      .wbData   (wbData)
   );

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic checkRegAddr(input string name,
                               input logic [regAddrWidth-1:0] actual,
                               input logic [regAddrWidth-1:0] expected);
      if (actual !== expected) begin
         abortRun($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   task automatic checkWord(input string name,
                            input logic [dataWidth-1:0] actual,
                            input logic [dataWidth-1:0] expected);
      if (actual !== expected) begin
         abortRun($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   // Loads header, program and expected list and randomizes filler addi immediates to $0
   task automatic loadStim();
      instrWord    word;
      logic [31:0] randVal;
      int          i;
      $readmemh(stimFile, stim);
      if ($isunknown(stim[0]) || $isunknown(stim[1])) begin
         abortRun("The stim file header could not be read");
      end
      progLen  = int'(stim[0]);
      expCount = int'(stim[1]);
      if (progLen < 1 || progLen > progDepth || expCount < 1 ||
          2 + progLen + 2 * expCount > stimDepth) begin
         abortRun("The stim file sizes are out of range");
      end
      expBase = 2 + progLen;
      for (i = 0; i < progLen; i++) begin
         word = stim[2 + i];
         if (word.iType.opcode == opAddi && word.iType.rt == '0) begin
            randVal        = $random(seed);
            word.iType.imm = randVal[15:0];
         end
         progMem[i] = word;
      end
   endtask

   // Past the end of the program reads as the zero word
   function automatic instrWord programWord(input logic [dataWidth-1:0] addr);
      int idx;
      idx = int'(addr >> 2);
      if (idx < progLen) begin
         return progMem[idx];
      end
      return '0;
   endfunction

   // Instruction port follows pc just after each edge
   initial begin
      instr = '0;
      forever begin
         @(posedge Clk);
         #driveDelay;
         instr = programWord(pc);
      end
   end

   // Writeback monitor sampled mid-cycle
   always @(negedge Clk) begin
      logic [regAddrWidth-1:0] expAddr;
      logic [dataWidth-1:0]    expData;
      if (!reset && $isunknown(wbEnable)) begin
         abortRun("The write enable is unknown after reset");
      end
      if (!reset && wbEnable) begin
         if (checkedCount >= expCount) begin
            abortRun("A register write arrived after the expected list was complete");
         end else begin
            expAddr = stim[expBase + 2 * checkedCount][regAddrWidth-1:0];
            expData = stim[expBase + 2 * checkedCount + 1];
            checkRegAddr("wbAddr", wbAddr, expAddr);
            checkWord("wbData", wbData, expData);
            checkedCount = checkedCount + 1;
         end
      end
   end

   // Watchdog sized from the program length
   initial begin
      wait (loaded);
      #((progLen * 10 + 50) * clkPeriod);
      abortRun($sformatf("Timeout: only %0d of %0d expected register writes arrived",
                         checkedCount, expCount));
   end

   initial begin
      checkedCount = 0;
      loaded       = 1'b0;
      seed         = 32'h1c88c371;
      loadStim();
      loaded = 1'b1;
      // Fetch starts at address zero once reset drops
      @(negedge reset);
      checkWord("pc", pc, '0);
      wait (checkedCount == expCount);
      // Quiet spell catches stray writes behind the final loop
      repeat (5) @(posedge Clk);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- compile.f
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsCore.sv
sim/clockGen.sv
sim/coreProps.sv
sim/coreTb.sv

//--- run.sh
#!/bin/sh
# Build the pipeline testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

logFile=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module coreTb -o coreTbSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
   echo "Verilator build failed with status $buildStatus"
   exit 1
fi

./obj_dir/coreTbSim > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "TEST RESULT: FAIL" "$logFile"; then
   echo "Failure reported in $logFile"
   exit 1
fi
if [ $runStatus -ne 0 ]; then
   echo "Simulation exited with status $runStatus"
   exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$logFile"; then
   echo "Simulation ended without a result line"
   exit 1
fi
exit 0

//--- sim/programStim.txt
// Word 0: program length, word 1: number of expected writes
// Then one program word per line, then expected writes as: register value
00000021
00000013
20010005  // addi $1, $0, 5
2002FFFD  // addi $2, $0, -3
00221820  // add  $3, $1, $2
00612022  // sub  $4, $3, $1
0081282A  // slt  $5, $4, $1
00413024  // and  $6, $2, $1
00853825  // or   $7, $4, $5
0024402A  // slt  $8, $1, $4
20000000  // addi $0, $0, filler
00014820  // add  $9, $0, $1
AC030008  // sw   $3, 8($0)
AC04000C  // sw   $4, 12($0)
8C0A0008  // lw   $10, 8($0)
01415820  // add  $11, $10, $1   load-use
8C0C000C  // lw   $12, 12($0)
002C6822  // sub  $13, $1, $12   load-use on rt
10290002  // beq  $1, $9, +2     taken
200E0001  // addi $14, skipped
200E0002  // addi $14, skipped
10220001  // beq  $1, $2, +1     not taken
20110022  // addi $17, $0, 0x22
200F0011  // addi $15, $0, 0x11
01EF8020  // add  $16, $15, $15
12110001  // beq  $16, $17, +1   waits on add
20120099  // addi $18, skipped
8C130008  // lw   $19, 8($0)
12630001  // beq  $19, $3, +1    waits on lw
20140077  // addi $20, skipped
12610001  // beq  $19, $1, +1    not taken
20140033  // addi $20, $0, 0x33
00210020  // add  $0, $1, $1
0014A825  // or   $21, $0, $20
1000FFFF  // beq  $0, $0, -1     final loop
01 00000005
02 FFFFFFFD
03 00000002
04 FFFFFFFD
05 00000001
06 00000005
07 FFFFFFFD
08 00000000
09 00000005
0A 00000002
0B 00000007
0C FFFFFFFD
0D 00000008
11 00000022
0F 00000011
10 00000022
13 00000002
14 00000033
15 00000033
